// File: Makefile
VERILATOR ?= verilator
TOP ?= spi_bridge_tb
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

// File: project.f
rtl/bridge_pkg.sv
rtl/spi_peripheral.sv
rtl/response_arbiter.sv
rtl/register_file.sv
rtl/checksum_unit.sv
rtl/spi_bridge_top.sv
sim/tb_clock.sv
sim/spi_bridge_assertions.sv
sim/spi_bridge_tb.sv

// File: rtl/bridge_pkg.sv
package bridge_pkg;

    // Peers on the response path, index 0 has priority
    localparam int PEER_COUNT = 2;

    localparam int REG_COUNT = 8;
    localparam int REG_ADDR_WIDTH = $clog2(REG_COUNT);

    // Chip ID answer
    localparam logic [7:0] OPCODE_CHIP_ID = 8'hDB;
    localparam logic [7:0] CHIP_ID = 8'h81;

    // Register file, operand 0 is the address
    localparam logic [7:0] OPCODE_REG_WRITE = 8'h10; // Operand 1 is the data
    localparam logic [7:0] OPCODE_REG_READ = 8'h11;

    // Checksum unit
    localparam logic [7:0] OPCODE_SUM_CLEAR = 8'h20;
    localparam logic [7:0] OPCODE_SUM_ADD = 8'h21;   // Every operand is summed
    localparam logic [7:0] OPCODE_SUM_READ = 8'h22;

    // Decoded SPI bytes, seen by every peer
    typedef struct packed {
        logic [7:0] opcode;        // Held for the whole transaction
        logic       opcode_valid;
        logic [7:0] operand;
        logic       operand_valid;
        logic [7:0] operand_count; // Operand number from 0
    } spi_command_t;

    // One byte back to the host
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
    } peer_response_t;

endpackage

// File: rtl/checksum_unit.sv
`timescale 1ns/1ps

module checksum_unit (
    input  logic clock,
    input  logic rst_n,
    input  bridge_pkg::spi_command_t command,
    output bridge_pkg::peer_response_t response
);

    import bridge_pkg::*;

    logic [7:0] sum;
    logic       clear_hit;
    logic       add_hit;
    logic       read_hit;

    assign clear_hit = command.opcode_valid && (command.opcode == OPCODE_SUM_CLEAR);
    assign read_hit = command.opcode_valid && (command.opcode == OPCODE_SUM_READ);
    assign add_hit = command.operand_valid && (command.opcode == OPCODE_SUM_ADD);

    // Eight bit add wraps modulo 256
    always_ff @(posedge clock) begin
        if (!rst_n || clear_hit) begin
            sum <= '0;
        end else if (add_hit) begin
            sum <= sum + command.operand;
        end
    end

    // Sum is answered on the opcode strobe
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response.valid <= 1'b0;
        end else begin
            response.valid <= read_hit;
        end
        if (read_hit) begin
            response.data <= sum;
        end
    end

endmodule

// File: rtl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic clock,
    input  logic rst_n,
    input  bridge_pkg::spi_command_t command,
    output bridge_pkg::peer_response_t response
);

    import bridge_pkg::*;

    logic [7:0]                registers [REG_COUNT];
    logic [REG_ADDR_WIDTH-1:0] address;
    logic [REG_ADDR_WIDTH-1:0] operand_address;
    logic                      is_write;
    logic                      is_read;
    logic                      address_hit;
    logic                      write_hit;
    logic                      read_hit;
    logic                      chip_id_hit;

    // Upper address bits alias onto the low three
    assign operand_address = command.operand[REG_ADDR_WIDTH-1:0];

    assign is_write = command.operand_valid && (command.opcode == OPCODE_REG_WRITE);
    assign is_read = command.operand_valid && (command.opcode == OPCODE_REG_READ);

    assign address_hit = (is_write || is_read) && (command.operand_count == 8'd0);
    assign write_hit = is_write && (command.operand_count == 8'd1);
    assign read_hit = is_read && (command.operand_count == 8'd0);
    assign chip_id_hit = command.opcode_valid && (command.opcode == OPCODE_CHIP_ID);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            address <= '0;
            for (int i = 0; i < REG_COUNT; i++) begin
                registers[i] <= '0;
            end
        end else begin
            if (address_hit) begin
                address <= operand_address;
            end
            if (write_hit) begin
                registers[address] <= command.operand; // Address from operand 0
            end
        end
    end

    // Read answers straight after operand 0
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response.valid <= 1'b0;
        end else begin
            response.valid <= chip_id_hit || read_hit;
        end
        if (chip_id_hit) begin
            response.data <= CHIP_ID;
        end else if (read_hit) begin
            response.data <= registers[operand_address];
        end
    end

endmodule

// File: rtl/response_arbiter.sv
`timescale 1ns/1ps

module response_arbiter (
    input  logic clock,
    input  logic rst_n,
    input  bridge_pkg::peer_response_t peer_responses [bridge_pkg::PEER_COUNT],
    output bridge_pkg::peer_response_t response
);

    import bridge_pkg::*;

    logic       grant_valid;
    logic [7:0] grant_data;

    // Lowest index wins, so scan downwards and let later hits override
    always_comb begin
        grant_valid = 1'b0;
        grant_data = '0;
        for (int i = PEER_COUNT - 1; i >= 0; i--) begin
            if (peer_responses[i].valid) begin
                grant_valid = 1'b1;
                grant_data = peer_responses[i].data;
            end
        end
    end

    // One register stage toward the SPI peripheral
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            response.valid <= 1'b0;
        end else begin
            response.valid <= grant_valid;
        end
        if (grant_valid) begin
            response.data <= grant_data;
        end
    end

endmodule

// File: rtl/spi_bridge_top.sv
`timescale 1ns/1ps

module spi_bridge_top (
    input  logic clock,
    input  logic rst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out
);

    import bridge_pkg::*;

    spi_command_t   command;
    peer_response_t peer_responses [PEER_COUNT];
    peer_response_t response;

    spi_peripheral spi_peripheral (
        .clock(clock),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out),
        .command(command),
        .response(response)
    );

    // Peer 0, also answers the chip ID
    register_file register_file (
        .clock(clock),
        .rst_n(rst_n),
        .command(command),
        .response(peer_responses[0])
    );

    checksum_unit checksum_unit (
        .clock(clock),
        .rst_n(rst_n),
        .command(command),
        .response(peer_responses[1])  // Peer 1
    );

    response_arbiter response_arbiter (
        .clock(clock),
        .rst_n(rst_n),
        .peer_responses(peer_responses),
        .response(response)
    );

endmodule

// File: rtl/spi_peripheral.sv
`timescale 1ns/1ps

module spi_peripheral (
    input  logic clock,
    input  logic rst_n,
    input  logic spi_select,
    input  logic spi_clock,
    input  logic spi_data_in,
    output logic spi_data_out,
    output bridge_pkg::spi_command_t command,
    input  bridge_pkg::peer_response_t response
);

    logic [1:0] select_sync;
    logic [1:0] clock_sync;
    logic [1:0] data_sync;
    logic       clock_prev;
    logic       selected;
    logic       rise_q;
    logic       fall_q;
    logic [2:0] bit_count;
    logic [7:0] rx_shift;
    logic       byte_done;
    logic       opcode_seen;
    logic [7:0] operand_index;
    logic [7:0] response_latched;
    logic [7:0] tx_shift;
    logic [7:0] tx_next;

    assign selected = ~select_sync[1];
    assign spi_data_out = tx_shift[7]; // MSB first

    // A response arriving on the load cycle itself is taken directly
    assign tx_next = response.valid ? response.data : response_latched;

    // Pins are oversampled through two flops each
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            select_sync <= 2'b11;
            clock_sync <= '0;
            data_sync <= '0;
            clock_prev <= 1'b0;
        end else begin
            select_sync <= {select_sync[0], spi_select};
            clock_sync <= {clock_sync[0], spi_clock};
            data_sync <= {data_sync[0], spi_data_in};
            clock_prev <= clock_sync[1];
        end
    end

    // Edge strobes land one cycle after the synchronized edge
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            rise_q <= selected & clock_sync[1] & ~clock_prev;
            fall_q <= selected & ~clock_sync[1] & clock_prev;
        end
    end

    // Bit counter, cleared whenever select is high
    always_ff @(posedge clock) begin
        if (!rst_n || !selected) begin
            bit_count <= '0;
            byte_done <= 1'b0;
        end else begin
            byte_done <= 1'b0;
            if (rise_q) begin
                bit_count <= bit_count + 3'd1;
                byte_done <= (bit_count == 3'd7); // Eighth bit in
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rise_q) begin
            rx_shift <= {rx_shift[6:0], data_sync[1]};
        end
    end

    // First byte is the opcode, the rest are numbered operands
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            command <= '0;
            opcode_seen <= 1'b0;
            operand_index <= '0;
        end else begin
            command.opcode_valid <= 1'b0;
            command.operand_valid <= 1'b0;
            if (!selected) begin
                opcode_seen <= 1'b0;
                operand_index <= '0;
            end else if (byte_done) begin
                if (!opcode_seen) begin
                    command.opcode <= rx_shift;
                    command.opcode_valid <= 1'b1;
                    opcode_seen <= 1'b1;
                end else begin
                    command.operand <= rx_shift;
                    command.operand_valid <= 1'b1;
                    command.operand_count <= operand_index;
                    operand_index <= operand_index + 8'd1;
                end
            end
        end
    end

    // Latched response goes out during the following byte
    always_ff @(posedge clock) begin
        if (!rst_n || !selected) begin
            response_latched <= '0;
            tx_shift <= '0;
        end else begin
            if (response.valid) begin
                response_latched <= response.data;
            end
            if (fall_q) begin
                if (bit_count == 3'd0) begin
                    tx_shift <= tx_next;                 // Byte boundary
                end else begin
                    tx_shift <= {tx_shift[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: sim/spi_bridge_assertions.sv
`timescale 1ns/1ps

module spi_bridge_assertions (
    input logic clock,
    input logic rst_n,
    input bridge_pkg::spi_command_t command,
    input bridge_pkg::peer_response_t peer_responses [bridge_pkg::PEER_COUNT],
    input bridge_pkg::peer_response_t response
);

    import bridge_pkg::*;

    logic [PEER_COUNT-1:0] peer_valids;
    int                    failure_count = 0; // Failed assertions so far

    always_comb begin
        for (int i = 0; i < PEER_COUNT; i++) begin
            peer_valids[i] = peer_responses[i].valid;
        end
    end

    // Arbiter output trails its peers by one register
    valid_has_source: assert property (@(posedge clock) disable iff (!rst_n)
        $rose(response.valid) |-> $past(|peer_valids))
        else begin
            $error("response valid rose with no peer valid one cycle earlier");
            failure_count++;
        end

    one_peer_at_a_time: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(peer_valids))
        else begin
            $error("more than one peer response valid, peer valids %b", peer_valids);
            failure_count++;
        end

    // Opcode and operand strobes come from different bytes
    single_command_strobe: assert property (@(posedge clock) disable iff (!rst_n)
        !(command.opcode_valid && command.operand_valid))
        else begin
            $error("opcode_valid and operand_valid high in the same cycle");
            failure_count++;
        end

endmodule

// File: sim/spi_bridge_tb.sv
`timescale 1ns/1ps

module spi_bridge_tb;

    import bridge_pkg::*;

    localparam int PHASE_CYCLES = 6;     // System clocks per SPI clock phase
    localparam int IDLE_TIMEOUT = 50;
    localparam int DRAIN_TIMEOUT = 50;

    logic clock;
    logic rst_n;
    logic spi_select;
    logic spi_clock;
    logic spi_data_in;
    logic spi_data_out;

    logic [7:0] model_regs [REG_COUNT];
    logic [7:0] model_sum;
    logic [7:0] ops [8];                 // Operand bytes of the next transaction
    logic [7:0] got_q [$];
    logic [7:0] expected_q [$];
    int         position_q [$];
    int         check_count;
    int         error_count;
    int         timeout_count;

    tb_clock clock_gen (.clock(clock));

    spi_bridge_top dut0 (
        .clock(clock),
        .rst_n(rst_n),
        .spi_select(spi_select),
        .spi_clock(spi_clock),
        .spi_data_in(spi_data_in),
        .spi_data_out(spi_data_out)
    );

    bind spi_bridge_top spi_bridge_assertions bridge_checks (
        .clock(clock),
        .rst_n(rst_n),
        .command(command),
        .peer_responses(peer_responses),
        .response(response)
    );

    // Reference model of the registers and the sum
    function automatic logic [7:0] expected_response(
        input  logic [7:0] opcode,
        input  logic [7:0] operands [8],
        input  int         operand_total,
        output int         answer_after  // Byte after which the answer appears
    );
        logic [7:0] answer;
        answer = 8'h00;
        answer_after = -1;               // No answer at all
        case (opcode)
            OPCODE_CHIP_ID: begin
                answer = CHIP_ID;
                answer_after = 0;
            end
            OPCODE_REG_WRITE: begin
                if (operand_total > 1) begin
                    model_regs[operands[0][REG_ADDR_WIDTH-1:0]] = operands[1];
                end
            end
            OPCODE_REG_READ: begin
                if (operand_total > 0) begin
                    answer = model_regs[operands[0][REG_ADDR_WIDTH-1:0]];
                    answer_after = 1;
                end
            end
            OPCODE_SUM_CLEAR: model_sum = 8'h00;
            OPCODE_SUM_ADD: begin
                for (int i = 0; i < operand_total; i++) begin
                    model_sum = model_sum + operands[i]; // Wraps at 256
                end
            end
            OPCODE_SUM_READ: begin
                answer = model_sum;
                answer_after = 0;
            end
            default: answer = 8'h00;
        endcase
        return answer;
    endfunction

    task automatic wait_cycles(input int count);
        for (int i = 0; i < count; i++) begin
            @(negedge clock);
        end
    endtask

    // Mode 0 host that samples just before its rising edge
    task automatic shift_byte(input logic [7:0] tx, output logic [7:0] rx);
        for (int i = 7; i >= 0; i--) begin
            spi_data_in = tx[i];
            wait_cycles(PHASE_CYCLES);
            rx[i] = spi_data_out;
            spi_clock = 1'b1;
            wait_cycles(PHASE_CYCLES);
            spi_clock = 1'b0;
        end
    endtask

    task automatic run_transaction(input logic [7:0] opcode, input int operand_total);
        logic [7:0] answer;
        logic [7:0] tx;
        logic [7:0] rx;
        int         answer_after;
        int         idle_wait;
        answer = expected_response(opcode, ops, operand_total, answer_after);
        spi_select = 1'b0;
        wait_cycles(PHASE_CYCLES);
        for (int k = 0; k <= operand_total; k++) begin
            if (k == 0) begin
                tx = opcode;
            end else begin
                tx = ops[k-1];
            end
            shift_byte(tx, rx);
            got_q.push_back(rx);
            expected_q.push_back((answer_after >= 0 && k > answer_after) ? answer : 8'h00);
            position_q.push_back(k);
        end
        wait_cycles(PHASE_CYCLES);
        spi_select = 1'b1;
        idle_wait = 0;
        while (spi_data_out !== 1'b0 && idle_wait < IDLE_TIMEOUT) begin
            @(negedge clock);
            idle_wait++;
        end
        if (spi_data_out !== 1'b0) begin
            timeout_count++;
            $display("Timeout: spi_data_out did not go low after select went high");
        end
        wait_cycles(PHASE_CYCLES);
    endtask

    // Compares one observed byte per clock
    always @(posedge clock) begin
        logic [7:0] got;
        logic [7:0] expected;
        int         position;
        if (got_q.size() > 0) begin
            got = got_q.pop_front();
            expected = expected_q.pop_front();
            position = position_q.pop_front();
            check_count++;
            if (got !== expected) begin
                error_count++;
                $display("ERROR: spi_data_out byte %0d read 0x%02h, expected 0x%02h",
                         position, got, expected);
            end
        end
    end

    initial begin
        logic [2:0] order [8];
        logic [2:0] address_low;
        logic [2:0] swap;
        int         j;
        int         drain_wait;
        rst_n = 1'b0;
        spi_select = 1'b1;
        spi_clock = 1'b0;
        spi_data_in = 1'b0;
        check_count = 0;
        error_count = 0;
        timeout_count = 0;
        model_sum = 8'h00;
        for (int i = 0; i < REG_COUNT; i++) begin
            model_regs[i] = 8'h00;
        end
        void'($urandom(6795));
        wait_cycles(8);
        rst_n = 1'b1;
        wait_cycles(4);

        ops[0] = 8'($urandom);           // Dummy byte carries the chip ID back
        run_transaction(OPCODE_CHIP_ID, 1);

        for (int a = 0; a < REG_COUNT; a++) begin
            ops[0] = 8'(a);
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_REG_WRITE, 2);
            order[a] = 3'(a);
        end
        for (int i = 7; i > 0; i--) begin
            j = int'($urandom % 32'(i + 1));
            swap = order[i];
            order[i] = order[j];
            order[j] = swap;
        end
        for (int a = 0; a < REG_COUNT; a++) begin
            ops[0] = 8'(order[a]);
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_REG_READ, 2);
        end

        // Upper address bits alias onto the low three
        for (int t = 0; t < 4; t++) begin
            address_low = 3'($urandom);
            ops[0] = {5'($urandom) | 5'b10000, address_low};
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_REG_WRITE, 2);
            ops[0] = {5'($urandom) | 5'b01000, address_low};
            run_transaction(OPCODE_REG_READ, 2);
        end

        run_transaction(OPCODE_SUM_CLEAR, 0);
        for (int t = 0; t < 4; t++) begin
            j = 1 + int'($urandom % 32'd6);
            for (int i = 0; i < j; i++) begin
                ops[i] = 8'($urandom);
            end
            run_transaction(OPCODE_SUM_ADD, j);
        end
        ops[0] = 8'($urandom);
        run_transaction(OPCODE_SUM_READ, 1);

        // Register and sum traffic interleaved
        for (int t = 0; t < 3; t++) begin
            ops[0] = 8'($urandom);
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_REG_WRITE, 2);
            ops[0] = 8'($urandom);
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_SUM_ADD, 2);
            ops[0] = 8'($urandom);
            run_transaction(OPCODE_SUM_READ, 1);
            ops[0] = 8'($urandom);
            ops[1] = 8'($urandom);
            run_transaction(OPCODE_REG_READ, 2);
        end

        drain_wait = 0;
        while (got_q.size() > 0 && drain_wait < DRAIN_TIMEOUT) begin
            @(negedge clock);
            drain_wait++;
        end
        if (got_q.size() > 0) begin
            timeout_count++;
            $display("Timeout: compare process left %0d bytes unchecked", got_q.size());
        end

        $display("Checks: %0d  errors: %0d  timeouts: %0d  assertion failures: %0d",
                 check_count, error_count, timeout_count,
                 dut0.bridge_checks.failure_count);
        if (error_count == 0 && timeout_count == 0 && check_count > 0
                && dut0.bridge_checks.failure_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// File: sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clock
);

    localparam int HALF_PERIOD_NS = 20; // 40 ns period

    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clock = ~clock;
        end
    end

endmodule
